// ==== dv/fu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_tb;

    localparam int MAX_ROWS = 1 << fu_pkg::TAG_W; // One unique tag per row
    localparam int MULT_U   = fu_pkg::FU_MULT_IDX;

    logic                                             clock;
    logic                                             rst_n;
    logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_valid;
    fu_pkg::alu_func_e [fu_pkg::NUM_FU_ALU-1:0]       alu_func;
    logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_is_branch;
    fu_pkg::br_func_e [fu_pkg::NUM_FU_ALU-1:0]        alu_br_func;
    logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_opa;
    logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_opb;
    logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_pc;
    logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_imm;
    logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::TAG_W-1:0] alu_tag;
    logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_avail;
    logic                                             mult_valid;
    fu_pkg::mult_func_e                               mult_func;
    logic [fu_pkg::XLEN-1:0]                          mult_opa;
    logic [fu_pkg::XLEN-1:0]                          mult_opb;
    logic [fu_pkg::TAG_W-1:0]                         mult_tag;
    logic                                             mult_avail;
    logic [fu_pkg::CDB_SZ-1:0]                        cdb_valid;
    logic [fu_pkg::CDB_SZ-1:0][fu_pkg::TAG_W-1:0]     cdb_tag;
    logic [fu_pkg::CDB_SZ-1:0][fu_pkg::XLEN-1:0]      cdb_value;
    logic [fu_pkg::CDB_SZ-1:0]                        cdb_take;

    // Stimulus table with expected results
    int          tbl_unit  [MAX_ROWS];
    logic [3:0]  tbl_func  [MAX_ROWS];
    logic        tbl_br    [MAX_ROWS];
    logic [2:0]  tbl_brf   [MAX_ROWS];
    logic [31:0] tbl_opa   [MAX_ROWS];
    logic [31:0] tbl_opb   [MAX_ROWS];
    logic [31:0] tbl_pc    [MAX_ROWS];
    logic [31:0] tbl_imm   [MAX_ROWS];
    logic [31:0] exp_value [MAX_ROWS];
    logic        exp_take  [MAX_ROWS];
    int          seen      [MAX_ROWS];
    int          n_rows;
    int          n_unique;
    int          errors;
    int          cycle_count;
    int          timeout_limit;
    logic [31:0] rng_state;

    fu dut0 (.*);

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31]; // Negative side is smaller
        end
        return a < b;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [3:0] f, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] filled;
        filled = {{32{a[31]}}, a} >> b[4:0];
        case (f)
            4'd0:    return a + b;
            4'd1:    return a + ~b + 32'd1;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return {31'd0, signed_less(a, b)};
            4'd6:    return {31'd0, a < b};
            4'd7:    return a << b[4:0];
            4'd8:    return a >> b[4:0];
            4'd9:    return filled[31:0];
            default: return 32'hx;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return signed_less(a, b);
            3'b101:  return !signed_less(a, b);
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] ref_mult(input logic [1:0] f, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = {{32{(f == 2'd1 || f == 2'd2) && a[31]}}, a}; // MULH and MULHSU sign a
        eb = {{32{(f == 2'd1) && b[31]}}, b};
        p  = ea * eb;
        return (f == 2'd0) ? p[31:0] : p[63:32];
    endfunction

    task automatic add_row(input int u, input logic [3:0] f, input logic br,
                           input logic [2:0] brf, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] pc, input logic [31:0] imm);
        tbl_unit[n_rows] = u;
        tbl_func[n_rows] = f;
        tbl_br[n_rows]   = br && (u != MULT_U);
        tbl_brf[n_rows]  = brf;
        tbl_opa[n_rows]  = a;
        tbl_opb[n_rows]  = b;
        tbl_pc[n_rows]   = pc;
        tbl_imm[n_rows]  = imm;
        if (u == MULT_U) begin
            exp_value[n_rows] = ref_mult(f[1:0], a, b);
            exp_take[n_rows]  = 1'b0;
        end else if (br) begin
            exp_value[n_rows] = pc + imm; // Branch target
            exp_take[n_rows]  = ref_branch(brf, a, b);
        end else begin
            exp_value[n_rows] = ref_alu(f, a, b);
            exp_take[n_rows]  = 1'b0;
        end
        seen[n_rows] = 0;
        n_rows       = n_rows + 1;
    endtask

    task automatic build_table();
        logic [2:0] br_list [6];
        int         u;
        br_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        add_row(0, fu_pkg::ALU_ADD,  0, 0, 32'h7fff_ffff, 32'h0000_0001, 0, 0);
        add_row(1, fu_pkg::ALU_SUB,  0, 0, 32'h0000_0000, 32'h0000_0001, 0, 0);
        add_row(0, fu_pkg::ALU_AND,  0, 0, 32'hf0f0_a5a5, 32'h0ff0_ffff, 0, 0);
        add_row(1, fu_pkg::ALU_OR,   0, 0, 32'h1234_0000, 32'h0000_5678, 0, 0);
        add_row(0, fu_pkg::ALU_XOR,  0, 0, 32'hdead_beef, 32'hffff_0000, 0, 0);
        add_row(1, fu_pkg::ALU_SLT,  0, 0, 32'h8000_0000, 32'h0000_0001, 0, 0);
        add_row(0, fu_pkg::ALU_SLTU, 0, 0, 32'h8000_0000, 32'h0000_0001, 0, 0);
        add_row(1, fu_pkg::ALU_SLT,  0, 0, 32'h0000_0001, 32'hffff_ffff, 0, 0);
        add_row(0, fu_pkg::ALU_SLL,  0, 0, 32'h0000_0001, 32'd33, 0, 0);   // Shift of 1
        add_row(1, fu_pkg::ALU_SRL,  0, 0, 32'h8000_0000, 32'h24, 0, 0);   // Shift of 4
        add_row(0, fu_pkg::ALU_SRA,  0, 0, 32'h8000_0000, 32'd35, 0, 0);
        // Each branch compare runs once on each ALU unit
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BEQ,  32'd5, 32'd5, 32'h1000, 32'h20);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BEQ,  32'd5, 32'd6, 32'h1004, 32'hffff_ffe0);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BNE,  32'd5, 32'd5, 32'h2000, 32'hffff_fff0);
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BNE,  32'h8000_0000, 32'd0, 32'h2004, 32'h10);
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BLT,  32'hffff_ffff, 32'd1, 32'h3000, 32'h8);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BLT,  32'd1, 32'hffff_ffff, 32'h3008, 32'h8);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BLTU, 32'hffff_ffff, 32'd1, 32'h3004, 32'h8);
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BLTU, 32'd1, 32'hffff_ffff, 32'h300c, 32'h8);
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BGE,  32'hffff_ffff, 32'd1, 32'h4000, 32'h100);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BGE,  32'd1, 32'hffff_ffff, 32'h4008, 32'h100);
        add_row(1, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BGEU, 32'hffff_ffff, 32'd1, 32'h4004, 32'h100);
        add_row(0, fu_pkg::ALU_ADD,  1, fu_pkg::BR_BGEU, 32'd7, 32'd7, 32'h5000, 32'h4);
        add_row(MULT_U, fu_pkg::MULT_MUL,    0, 0, 32'h0000_0007, 32'hffff_fffd, 0, 0);
        add_row(MULT_U, fu_pkg::MULT_MULH,   0, 0, 32'hffff_fffd, 32'h0000_0007, 0, 0);
        add_row(MULT_U, fu_pkg::MULT_MULH,   0, 0, 32'h8000_0000, 32'h8000_0000, 0, 0);
        add_row(MULT_U, fu_pkg::MULT_MULHSU, 0, 0, 32'hffff_ffff, 32'hffff_ffff, 0, 0);
        add_row(MULT_U, fu_pkg::MULT_MULHU,  0, 0, 32'hffff_ffff, 32'hffff_ffff, 0, 0);
        add_row(MULT_U, fu_pkg::MULT_MUL,    0, 0, 32'h1234_5678, 32'h9abc_def0, 0, 0);
        while (n_rows < MAX_ROWS) begin // Random rows fill the remaining tags
            rng_state = xorshift(rng_state);
            u = n_rows % fu_pkg::NUM_FU; // Rotate so every unit gets a random row
            if (u == MULT_U) begin
                add_row(u, rng_state[9:8], 0, 0, xorshift(rng_state), xorshift(~rng_state), 0, 0);
            end else begin
                add_row(u, 4'(rng_state[15:8] % 10), rng_state[3], br_list[rng_state[23:16] % 6],
                        xorshift(rng_state), xorshift(~rng_state), {rng_state[31:2], 2'b00},
                        {{20{rng_state[20]}}, rng_state[11:0]});
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, expected);
            errors = errors + 1;
        end
    endtask

    function automatic int find_next(input int u, input int start);
        for (int r = start; r < n_rows; r++) begin
            if (tbl_unit[r] == u) begin
                return r;
            end
        end
        return n_rows;
    endfunction

    function automatic logic unit_avail(input int u);
        return (u == MULT_U) ? mult_avail : alu_avail[u];
    endfunction

    task automatic drive_row(input int u, input int r);
        if (u == MULT_U) begin
            mult_valid = 1'b1;
            mult_func  = fu_pkg::mult_func_e'(tbl_func[r][1:0]);
            mult_opa   = tbl_opa[r];
            mult_opb   = tbl_opb[r];
            mult_tag   = fu_pkg::TAG_W'(r);
        end else begin
            alu_valid[u]     = 1'b1;
            alu_func[u]      = fu_pkg::alu_func_e'(tbl_func[r]);
            alu_is_branch[u] = tbl_br[r];
            alu_br_func[u]   = fu_pkg::br_func_e'(tbl_brf[r]);
            alu_opa[u]       = tbl_opa[r];
            alu_opb[u]       = tbl_opb[r];
            alu_pc[u]        = tbl_pc[r];
            alu_imm[u]       = tbl_imm[r];
            alu_tag[u]       = fu_pkg::TAG_W'(r);
        end
    endtask

    task automatic drop_valid(input int u);
        if (u == MULT_U) begin
            mult_valid = 1'b0;
        end else begin
            alu_valid[u] = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: results still missing after %0d cycles", timeout_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // CDB outputs are settled mid-cycle, one sample per broadcast
    always @(negedge clock) begin : collect
        int t;
        int v;
        if (rst_n) begin
            v = cdb_valid;
            if ((v & (v + 1)) != 0) begin // Slots fill from slot 0 upward
                $display("A higher CDB slot was valid while a lower slot stayed idle");
                errors = errors + 1;
            end
            for (int s = 0; s < fu_pkg::CDB_SZ; s++) begin
                if (cdb_valid[s]) begin
                    if ($isunknown(cdb_tag[s])) begin
                        $display("CDB slot %0d carried an unknown tag", s);
                        errors = errors + 1;
                    end else begin
                        t = cdb_tag[s];
                        if (seen[t] == 0) begin
                            n_unique = n_unique + 1;
                        end
                        seen[t] = seen[t] + 1;
                        check_value($sformatf("cdb_value[%0d] tag %0d", s, t), cdb_value[s],
                                    exp_value[t]);
                        check_value($sformatf("cdb_take[%0d] tag %0d", s, t), 32'(cdb_take[s]),
                                    32'(exp_take[t]));
                    end
                end
            end
        end
    end

    initial begin : main
        int next_row [fu_pkg::NUM_FU];
        int missing;
        int dups;
        clock         = 1'b0;
        rst_n         = 1'b0;
        alu_valid     = '0;
        alu_is_branch = '0;
        alu_opa       = '0;
        alu_opb       = '0;
        alu_pc        = '0;
        alu_imm       = '0;
        alu_tag       = '0;
        mult_valid    = 1'b0;
        mult_func     = fu_pkg::MULT_MUL;
        mult_opa      = '0;
        mult_opb      = '0;
        mult_tag      = '0;
        for (int u = 0; u < fu_pkg::NUM_FU_ALU; u++) begin
            alu_func[u]    = fu_pkg::ALU_ADD;
            alu_br_func[u] = fu_pkg::BR_BEQ;
        end
        n_rows        = 0;
        n_unique      = 0;
        errors        = 0;
        missing       = 0;
        dups          = 0;
        cycle_count   = 0;
        rng_state     = 32'h6b22_aad6;
        build_table();
        timeout_limit = 20 * n_rows + 50;

        repeat (3) @(posedge clock);
        #1 rst_n = 1'b1;
        @(negedge clock);
        check_value("cdb_valid after reset", 32'(cdb_valid), 32'h0);
        check_value("alu_avail after reset", 32'(alu_avail), 32'h3);
        check_value("mult_avail after reset", 32'(mult_avail), 32'h1);

        for (int u = 0; u < fu_pkg::NUM_FU; u++) begin
            next_row[u] = find_next(u, 0);
        end
        @(posedge clock);
        #1;
        while (next_row[0] < n_rows || next_row[1] < n_rows || next_row[MULT_U] < n_rows) begin
            for (int u = 0; u < fu_pkg::NUM_FU; u++) begin
                if (next_row[u] < n_rows && unit_avail(u)) begin
                    drive_row(u, next_row[u]);
                    next_row[u] = find_next(u, next_row[u] + 1);
                end else begin
                    drop_valid(u);
                end
            end
            @(posedge clock);
            #1;
        end
        for (int u = 0; u < fu_pkg::NUM_FU; u++) begin
            drop_valid(u);
        end

        while (n_unique < n_rows) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock); // Window for late duplicates

        for (int r = 0; r < n_rows; r++) begin
            if (seen[r] == 0) begin
                $display("Tag %0d never appeared on the CDB", r);
                missing = missing + 1;
            end else if (seen[r] > 1) begin
                $display("Tag %0d appeared %0d times on the CDB", r, seen[r]);
                dups = dups + 1;
            end
        end
        $display("Errors: %0d check failures, %0d missing tags, %0d duplicated tags",
                 errors, missing, dups);
        if (errors == 0 && missing == 0 && dups == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/fu_pkg.sv
src/alu.sv
src/conditional_branch.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/fu.sv
dv/fu_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [fu_pkg::XLEN-1:0] opa,
    input  logic [fu_pkg::XLEN-1:0] opb,
    input  fu_pkg::alu_func_e       func,
    output logic [fu_pkg::XLEN-1:0] result
);

    logic signed [fu_pkg::XLEN-1:0]   signed_opa;
    logic signed [fu_pkg::XLEN-1:0]   signed_opb;
    logic [$clog2(fu_pkg::XLEN)-1:0]  shamt;
    logic                             lt_signed;
    logic                             lt_unsigned;

    assign signed_opa  = opa;
    assign signed_opb  = opb;
    assign shamt       = opb[$clog2(fu_pkg::XLEN)-1:0]; // Only the low five bits count
    assign lt_signed   = signed_opa < signed_opb;
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            fu_pkg::ALU_ADD:  result = opa + opb;
            fu_pkg::ALU_SUB:  result = opa - opb;
            fu_pkg::ALU_AND:  result = opa & opb;
            fu_pkg::ALU_OR:   result = opa | opb;
            fu_pkg::ALU_XOR:  result = opa ^ opb;
            fu_pkg::ALU_SLT:  result = {{(fu_pkg::XLEN-1){1'b0}}, lt_signed};
            fu_pkg::ALU_SLTU: result = {{(fu_pkg::XLEN-1){1'b0}}, lt_unsigned};
            fu_pkg::ALU_SLL:  result = opa << shamt;
            fu_pkg::ALU_SRL:  result = opa >> shamt;
            fu_pkg::ALU_SRA:  result = signed_opa >>> shamt; // Sign bit fills from the left
            default:          result = fu_pkg::ALU_FILL;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     valid,
    input  fu_pkg::alu_func_e        func,
    input  logic                     is_branch,
    input  fu_pkg::br_func_e         br_func,
    input  logic [fu_pkg::XLEN-1:0]  opa,
    input  logic [fu_pkg::XLEN-1:0]  opb,
    input  logic [fu_pkg::XLEN-1:0]  pc,
    input  logic [fu_pkg::XLEN-1:0]  imm,
    input  logic [fu_pkg::TAG_W-1:0] tag,
    input  logic                     grant,
    output logic                     avail,
    output logic                     ready,
    output logic [fu_pkg::XLEN-1:0]  value,
    output logic [fu_pkg::TAG_W-1:0] result_tag,
    output logic                     take
);

    fu_pkg::alu_func_e        alu_f;
    logic [fu_pkg::XLEN-1:0]  alu_a;
    logic [fu_pkg::XLEN-1:0]  alu_b;
    logic [fu_pkg::XLEN-1:0]  alu_result;
    logic                     br_take;
    logic                     accept;

    // A branch borrows the adder to form its target pc + imm
    assign alu_a = is_branch ? pc : opa;
    assign alu_b = is_branch ? imm : opb;
    assign alu_f = is_branch ? fu_pkg::ALU_ADD : func;

    alu u_alu (
        .opa    (alu_a),
        .opb    (alu_b),
        .func   (alu_f),
        .result (alu_result)
    );

    conditional_branch u_conditional_branch (
        .func (br_func),
        .rs1  (opa),
        .rs2  (opb),
        .take (br_take)
    );

    assign avail  = !ready || grant; // Free, or draining this cycle
    assign accept = valid && avail;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else if (accept) begin
            ready <= 1'b1;
        end else if (grant) begin
            ready <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            value      <= alu_result;
            result_tag <= tag;
            take       <= is_branch && br_take; // Low for plain ALU ops
        end
    end

    a_no_issue_when_busy: assert property (
        @(posedge clock) disable iff (!rst_n) valid |-> avail
    ) else $error("alu_unit: issue while the held result is not granted");

endmodule

`default_nettype wire

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic [fu_pkg::NUM_FU-1:0]                      ready,
    input  logic [fu_pkg::NUM_FU-1:0][fu_pkg::XLEN-1:0]    value,
    input  logic [fu_pkg::NUM_FU-1:0][fu_pkg::TAG_W-1:0]   tag,
    input  logic [fu_pkg::NUM_FU-1:0]                      take,
    output logic [fu_pkg::NUM_FU-1:0]                      grant,
    output logic [fu_pkg::CDB_SZ-1:0]                      cdb_valid,
    output logic [fu_pkg::CDB_SZ-1:0][fu_pkg::TAG_W-1:0]   cdb_tag,
    output logic [fu_pkg::CDB_SZ-1:0][fu_pkg::XLEN-1:0]    cdb_value,
    output logic [fu_pkg::CDB_SZ-1:0]                      cdb_take
);

    always_comb begin
        int slot;
        int u;
        grant     = '0;
        cdb_valid = '0;
        cdb_tag   = '0;
        cdb_value = '0;
        cdb_take  = '0;
        slot      = 0;
        for (int p = 0; p < fu_pkg::NUM_FU; p++) begin
            // Multipliers first, then ALUs in index order
            if (p < fu_pkg::NUM_FU_MULT) begin
                u = fu_pkg::FU_MULT_IDX + p;
            end else begin
                u = p - fu_pkg::NUM_FU_MULT;
            end
            if (ready[u] && slot < fu_pkg::CDB_SZ) begin
                grant[u]        = 1'b1;
                cdb_valid[slot] = 1'b1;
                cdb_tag[slot]   = tag[u];
                cdb_value[slot] = value[u];
                cdb_take[slot]  = take[u];
                slot            = slot + 1;
            end
        end
    end

    // Grant bookkeeping checks, evaluated once the comb logic settles
    always_comb begin
        int n_ready;
        int n_grant;
        int n_slots;
        n_ready = $countones(ready);
        n_grant = $countones(grant);
        n_slots = $countones(cdb_valid);
        a_single_grant: assert final (n_slots == n_grant)
            else $error("cdb_arbiter: a unit holds more than one slot");
        a_grant_ready: assert final ((grant & ~ready) == '0)
            else $error("cdb_arbiter: grant to a unit that is not ready");
        a_grant_count: assert final (n_grant == ((n_ready < fu_pkg::CDB_SZ) ? n_ready
                                                                             : fu_pkg::CDB_SZ))
            else $error("cdb_arbiter: grant count does not match ready count");
    end

endmodule

`default_nettype wire

// ==== src/conditional_branch.sv ====
`timescale 1ns/10ps
`default_nettype none

module conditional_branch (
    input  fu_pkg::br_func_e        func,
    input  logic [fu_pkg::XLEN-1:0] rs1,
    input  logic [fu_pkg::XLEN-1:0] rs2,
    output logic                    take
);

    logic signed [fu_pkg::XLEN-1:0] signed_rs1;
    logic signed [fu_pkg::XLEN-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            fu_pkg::BR_BEQ:  take = rs1 == rs2;
            fu_pkg::BR_BNE:  take = rs1 != rs2;
            fu_pkg::BR_BLT:  take = signed_rs1 <  signed_rs2;
            fu_pkg::BR_BGE:  take = signed_rs1 >= signed_rs2;
            fu_pkg::BR_BLTU: take = rs1 <  rs2;
            fu_pkg::BR_BGEU: take = rs1 >= rs2;
            default:         take = 1'b0; // funct3 010 and 011 are not branches
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fu.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu (
    input  logic                                             clock,
    input  logic                                             rst_n,

    input  logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_valid,
    input  fu_pkg::alu_func_e [fu_pkg::NUM_FU_ALU-1:0]       alu_func,
    input  logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_is_branch,
    input  fu_pkg::br_func_e [fu_pkg::NUM_FU_ALU-1:0]        alu_br_func,
    input  logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_opa,
    input  logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_opb,
    input  logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_pc,
    input  logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::XLEN-1:0]  alu_imm,
    input  logic [fu_pkg::NUM_FU_ALU-1:0][fu_pkg::TAG_W-1:0] alu_tag,
    output logic [fu_pkg::NUM_FU_ALU-1:0]                    alu_avail,

    input  logic                                             mult_valid,
    input  fu_pkg::mult_func_e                               mult_func,
    input  logic [fu_pkg::XLEN-1:0]                          mult_opa,
    input  logic [fu_pkg::XLEN-1:0]                          mult_opb,
    input  logic [fu_pkg::TAG_W-1:0]                         mult_tag,
    output logic                                             mult_avail,

    output logic [fu_pkg::CDB_SZ-1:0]                        cdb_valid,
    output logic [fu_pkg::CDB_SZ-1:0][fu_pkg::TAG_W-1:0]     cdb_tag,
    output logic [fu_pkg::CDB_SZ-1:0][fu_pkg::XLEN-1:0]      cdb_value,
    output logic [fu_pkg::CDB_SZ-1:0]                        cdb_take
);

    logic [fu_pkg::NUM_FU-1:0]                    fu_ready;
    logic [fu_pkg::NUM_FU-1:0][fu_pkg::XLEN-1:0]  fu_value;
    logic [fu_pkg::NUM_FU-1:0][fu_pkg::TAG_W-1:0] fu_tag;
    logic [fu_pkg::NUM_FU-1:0]                    fu_take;
    logic [fu_pkg::NUM_FU-1:0]                    fu_grant;

    for (genvar i = 0; i < fu_pkg::NUM_FU_ALU; i++) begin : g_alu
        alu_unit u_alu_unit (
            .clock      (clock),
            .rst_n      (rst_n),
            .valid      (alu_valid[i]),
            .func       (alu_func[i]),
            .is_branch  (alu_is_branch[i]),
            .br_func    (alu_br_func[i]),
            .opa        (alu_opa[i]),
            .opb        (alu_opb[i]),
            .pc         (alu_pc[i]),
            .imm        (alu_imm[i]),
            .tag        (alu_tag[i]),
            .grant      (fu_grant[i]),
            .avail      (alu_avail[i]),
            .ready      (fu_ready[i]),
            .value      (fu_value[i]),
            .result_tag (fu_tag[i]),
            .take       (fu_take[i])
        );
    end

    assign fu_take[fu_pkg::FU_MULT_IDX] = 1'b0; // Multiplies never branch

    mult_unit u_mult_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .valid      (mult_valid),
        .func       (mult_func),
        .opa        (mult_opa),
        .opb        (mult_opb),
        .tag        (mult_tag),
        .grant      (fu_grant[fu_pkg::FU_MULT_IDX]),
        .avail      (mult_avail),
        .ready      (fu_ready[fu_pkg::FU_MULT_IDX]),
        .value      (fu_value[fu_pkg::FU_MULT_IDX]),
        .result_tag (fu_tag[fu_pkg::FU_MULT_IDX])
    );

    cdb_arbiter u_cdb_arbiter (
        .ready     (fu_ready),
        .value     (fu_value),
        .tag       (fu_tag),
        .take      (fu_take),
        .grant     (fu_grant),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .cdb_take  (cdb_take)
    );

endmodule

`default_nettype wire

// ==== src/fu_pkg.sv ====
`default_nettype none

package fu_pkg;

    localparam int XLEN        = 32;
    localparam int TAG_W       = 5;

    localparam int NUM_FU_ALU  = 2;
    localparam int NUM_FU_MULT = 1;
    localparam int NUM_FU      = NUM_FU_ALU + NUM_FU_MULT; // Result sources on the arbiter
    localparam int CDB_SZ      = 2;

    // Unit order on the arbiter request vector is ALU 0, ALU 1, then multiplier
    localparam int FU_MULT_IDX = NUM_FU_ALU;

    localparam int MULT_STAGES  = 4;
    localparam int MULT_DIGIT_W = 16;                     // Width of one partial-product digit
    localparam int MULT_DIGITS  = 2 * XLEN / MULT_DIGIT_W;

    localparam logic [XLEN-1:0] ALU_FILL = 32'hfacebeec; // Returned for an unknown opcode

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    // Encodings follow the funct3 field of the RV32 branch instructions
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_func_e;

    typedef enum logic [1:0] {
        MULT_MUL    = 2'd0,
        MULT_MULH   = 2'd1,
        MULT_MULHSU = 2'd2,
        MULT_MULHU  = 2'd3
    } mult_func_e;

endpackage

`default_nettype wire

// ==== src/mult_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mult_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     valid,
    input  fu_pkg::mult_func_e       func,
    input  logic [fu_pkg::XLEN-1:0]  opa,
    input  logic [fu_pkg::XLEN-1:0]  opb,
    input  logic [fu_pkg::TAG_W-1:0] tag,
    input  logic                     grant,
    output logic                     avail,
    output logic                     ready,
    output logic [fu_pkg::XLEN-1:0]  value,
    output logic [fu_pkg::TAG_W-1:0] result_tag
);

    logic                         stall;
    logic                         accept;
    logic                         a_signed;
    logic                         b_signed;

    logic [fu_pkg::MULT_STAGES-1:0] stage_valid;
    logic [fu_pkg::TAG_W-1:0]       stage_tag  [fu_pkg::MULT_STAGES];
    fu_pkg::mult_func_e             stage_func [fu_pkg::MULT_STAGES-1];

    logic signed [fu_pkg::XLEN:0]   s1_a;  // Operands widened by one bit
    logic signed [fu_pkg::XLEN:0]   s1_b;
    logic [2*fu_pkg::XLEN-1:0]      a_wide;
    logic [2*fu_pkg::XLEN-1:0]      b_wide;
    logic [2*fu_pkg::XLEN-1:0]      pp    [fu_pkg::MULT_DIGITS];
    logic [2*fu_pkg::XLEN-1:0]      s2_pp [fu_pkg::MULT_DIGITS];
    logic [2*fu_pkg::XLEN-1:0]      pp_sum;
    logic [2*fu_pkg::XLEN-1:0]      s3_prod;

    assign ready      = stage_valid[fu_pkg::MULT_STAGES-1];
    assign result_tag = stage_tag[fu_pkg::MULT_STAGES-1];
    assign stall      = ready && !grant; // Whole pipe freezes behind an ungranted result
    assign avail      = !stall;
    assign accept     = valid && avail;

    assign a_signed = (func == fu_pkg::MULT_MULH) || (func == fu_pkg::MULT_MULHSU);
    assign b_signed = (func == fu_pkg::MULT_MULH);

    // Sign extension to the full product width keeps the low 64 bits exact
    assign a_wide = s1_a;
    assign b_wide = s1_b;

    always_comb begin
        pp_sum = '0;
        for (int j = 0; j < fu_pkg::MULT_DIGITS; j++) begin
            pp[j] = (a_wide * (2*fu_pkg::XLEN)'(b_wide[j*fu_pkg::MULT_DIGIT_W +: fu_pkg::MULT_DIGIT_W]))
                    << (j * fu_pkg::MULT_DIGIT_W);
            pp_sum = pp_sum + s2_pp[j];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid <= {stage_valid[fu_pkg::MULT_STAGES-2:0], accept};
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            stage_tag[0]  <= tag;
            stage_func[0] <= func;
            for (int k = 1; k < fu_pkg::MULT_STAGES; k++) begin
                stage_tag[k] <= stage_tag[k-1];
            end
            for (int k = 1; k < fu_pkg::MULT_STAGES-1; k++) begin
                stage_func[k] <= stage_func[k-1];
            end
            s1_a    <= {a_signed && opa[fu_pkg::XLEN-1], opa};
            s1_b    <= {b_signed && opb[fu_pkg::XLEN-1], opb};
            s2_pp   <= pp;     // Stage 2 partial products
            s3_prod <= pp_sum; // Stage 3 sum
            if (stage_func[fu_pkg::MULT_STAGES-2] == fu_pkg::MULT_MUL) begin
                value <= s3_prod[fu_pkg::XLEN-1:0];
            end else begin
                value <= s3_prod[2*fu_pkg::XLEN-1:fu_pkg::XLEN];
            end
        end
    end

    a_no_issue_in_stall: assert property (
        @(posedge clock) disable iff (!rst_n) stall |-> !valid
    ) else $error("mult_unit: issue while the pipeline is stalled");

endmodule

`default_nettype wire
